// ==== include/pcie_wr_config.svh ====
`ifndef PCIE_WR_CONFIG_SVH
`define PCIE_WR_CONFIG_SVH

// AXI side widths
`define PCIE_WR_ADDR_W 32
`define PCIE_WR_LEN_W 4

// beat storage, room for two full 16-beat bursts
`define PCIE_WR_FIFO_DEPTH 32

// TLP dword 0 codes
`define PCIE_WR_FMT_MWR 2'd2   // 3dw header with data
`define PCIE_WR_TYPE_MEM 5'd0  // memory request

// B channel responses
`define PCIE_WR_RESP_OKAY 2'd0
`define PCIE_WR_RESP_SLVERR 2'd2

`endif

// ==== logic/pcie_wr_pkg.sv ====
`include "pcie_wr_config.svh"

package pcie_wr_pkg;

    // one accepted AXI write burst, as seen by the header stage
    typedef struct packed {
        logic [`PCIE_WR_ADDR_W-1:2] addr;  // dword address
        logic [4:0]                 len;   // 1..16 dwords
        logic [3:0]                 first_be;
        logic [3:0]                 last_be;  // zero for single beat
    } wr_cmd_t;

    // PCIe requester id, bus/device/function
    typedef struct packed {
        logic [7:0] bus;
        logic [4:0] dev;
        logic [2:0] func;
    } req_id_t;

    // header record handed to the transmit stage
    // dw[0] goes out first
    typedef struct packed {
        logic [2:0][31:0] dw;
        logic [4:0]       beats;  // payload words to send or drain
        logic             drop;   // bus mastering was off
    } tlp_hdr_t;

endpackage

// ==== logic/wr_beat_fifo.sv ====
`timescale 1ns/1ps
`include "pcie_wr_config.svh"

module wr_beat_fifo (
    input  logic        axi_clk,
    input  logic        reset,
    input  logic        push,
    input  logic [31:0] push_data,
    output logic        full,
    input  logic        pop,
    output logic [31:0] head,
    output logic        not_empty
);

    localparam int PTR_W = $clog2(`PCIE_WR_FIFO_DEPTH);

    logic [31:0]    mem [0:`PCIE_WR_FIFO_DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;  // occupancy
    logic           do_push;
    logic           do_pop;

    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;
    assign full      = (count == (PTR_W+1)'(`PCIE_WR_FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];  // show-ahead read

    always_ff @(posedge axi_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge axi_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== logic/wr_cmd_stage.sv ====
`timescale 1ns/1ps
`include "pcie_wr_config.svh"

module wr_cmd_stage (
    input  logic                        axi_clk,
    input  logic                        reset,
    input  logic                        aw_valid,
    output logic                        aw_ready,
    input  logic [`PCIE_WR_ADDR_W-1:0]  aw_addr,
    input  logic [`PCIE_WR_LEN_W-1:0]   aw_len,
    input  logic                        w_valid,
    output logic                        w_ready,
    input  logic [31:0]                 w_data,
    input  logic [3:0]                  w_strb,
    input  logic                        w_last,
    input  logic                        fifo_full,
    output logic                        push,
    output logic [31:0]                 push_data,
    output logic                        cmd_valid,
    input  logic                        cmd_ready,
    output pcie_wr_pkg::wr_cmd_t        cmd
);

    logic addr_held;   // AW taken, command not yet handed on
    logic first_beat;  // next W beat opens the burst
    logic aw_take;
    logic w_take;

    assign aw_ready = !addr_held;
    // no more beats once the command is up, next burst waits for its AW
    assign w_ready  = addr_held && !cmd_valid && !fifo_full;

    assign aw_take   = aw_valid && aw_ready;
    assign w_take    = w_valid && w_ready;
    assign push      = w_take;  // every beat goes straight to the FIFO
    assign push_data = w_data;

    // command payload
    always_ff @(posedge axi_clk) begin
        if (aw_take) begin
            cmd.addr <= aw_addr[`PCIE_WR_ADDR_W-1:2];
            cmd.len  <= 5'(aw_len) + 5'd1;
        end
        if (w_take && first_beat) begin
            cmd.first_be <= w_strb;
        end
        if (w_take && w_last) begin
            cmd.last_be <= first_beat ? 4'b0000 : w_strb;  // middle strobes dropped
        end
    end

    always_ff @(posedge axi_clk) begin
        if (reset) begin
            addr_held  <= 1'b0;
            first_beat <= 1'b0;
            cmd_valid  <= 1'b0;
        end else begin
            if (aw_take) begin
                addr_held  <= 1'b1;
                first_beat <= 1'b1;
            end
            if (w_take) begin
                first_beat <= 1'b0;
                if (w_last) cmd_valid <= 1'b1;
            end
            if (cmd_valid && cmd_ready) begin
                cmd_valid <= 1'b0;
                addr_held <= 1'b0;  // frees AW for the next burst
            end
        end
    end

endmodule

// ==== logic/tlp_hdr_stage.sv ====
`timescale 1ns/1ps
`include "pcie_wr_config.svh"

module tlp_hdr_stage (
    input  logic                    axi_clk,
    input  logic                    reset,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  pcie_wr_pkg::wr_cmd_t    cmd,
    input  pcie_wr_pkg::req_id_t    req_id,
    input  logic                    dma_en,
    output logic                    hdr_valid,
    input  logic                    hdr_ready,
    output pcie_wr_pkg::tlp_hdr_t   hdr
);

    logic cmd_take;

    // single output register, refilled in the cycle it empties
    assign cmd_ready = !hdr_valid || hdr_ready;
    assign cmd_take  = cmd_valid && cmd_ready;

    always_ff @(posedge axi_clk) begin
        if (cmd_take) begin
            // fmt/type, tc, td/ep/attr all zero, length 16 stays 16
            hdr.dw[0] <= {1'b0, `PCIE_WR_FMT_MWR, `PCIE_WR_TYPE_MEM, 1'b0, 3'b000,
                          4'b0000, 1'b0, 1'b0, 2'b00, 2'b00, 5'd0, cmd.len};
            hdr.dw[1] <= {req_id, 8'h00, cmd.last_be, cmd.first_be};  // tag 0
            hdr.dw[2] <= {cmd.addr, 2'b00};
            hdr.beats <= cmd.len;
            hdr.drop  <= !dma_en;  // bus mastering off
        end
    end

    always_ff @(posedge axi_clk) begin
        if (reset) begin
            hdr_valid <= 1'b0;
        end else if (cmd_take) begin
            hdr_valid <= 1'b1;
        end else if (hdr_ready) begin
            hdr_valid <= 1'b0;
        end
    end

endmodule

// ==== logic/tlp_tx_stage.sv ====
`timescale 1ns/1ps
`include "pcie_wr_config.svh"

module tlp_tx_stage (
    input  logic                    axi_clk,
    input  logic                    reset,
    input  logic                    hdr_valid,
    output logic                    hdr_ready,
    input  pcie_wr_pkg::tlp_hdr_t   hdr,
    input  logic [31:0]             head,
    input  logic                    not_empty,
    output logic                    pop,
    output logic                    tx_valid,
    input  logic                    tx_ready,
    output logic [31:0]             tx_data,
    output logic                    tx_last,
    output logic                    b_valid,
    input  logic                    b_ready,
    output logic [1:0]              b_resp
);

    typedef enum logic [1:0] {
        ST_HDR,
        ST_PAY,
        ST_DRAIN,
        ST_RESP
    } tx_state_t;

    tx_state_t  state;
    logic [4:0] cnt;  // header word index, then payload words left

    // header record stays put upstream until B completes
    assign hdr_ready = (state == ST_RESP) && b_ready;
    assign b_valid   = (state == ST_RESP);
    assign b_resp    = hdr.drop ? `PCIE_WR_RESP_SLVERR : `PCIE_WR_RESP_OKAY;

    always_comb begin
        tx_valid = 1'b0;
        tx_data  = head;
        tx_last  = 1'b0;
        pop      = 1'b0;
        case (state)
            ST_HDR: begin
                tx_valid = hdr_valid && !hdr.drop;
                tx_data  = hdr.dw[cnt[1:0]];
            end
            ST_PAY: begin
                tx_valid = not_empty;  // beats already stored, head stable until popped
                tx_last  = (cnt == 5'd1);
                pop      = not_empty && tx_ready;
            end
            ST_DRAIN: begin
                pop = not_empty;  // discard, tx stays idle
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge axi_clk) begin
        if (reset) begin
            state <= ST_HDR;
            cnt   <= '0;
        end else begin
            case (state)
                ST_HDR: begin
                    if (hdr_valid && hdr.drop) begin
                        state <= ST_DRAIN;
                        cnt   <= hdr.beats;
                    end else if (hdr_valid && tx_ready) begin
                        if (cnt == 5'd2) begin  // third header dword out
                            state <= ST_PAY;
                            cnt   <= hdr.beats;
                        end else begin
                            cnt <= cnt + 5'd1;
                        end
                    end
                end
                ST_PAY, ST_DRAIN: begin
                    if (pop) begin
                        cnt <= cnt - 5'd1;  // ends at zero for the next header
                        if (cnt == 5'd1) state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (b_ready) state <= ST_HDR;
                end
                default: state <= ST_HDR;
            endcase
        end
    end

endmodule

// ==== logic/pcie_wr_bridge.sv ====
`timescale 1ns/1ps
`include "pcie_wr_config.svh"

module pcie_wr_bridge (
    input  logic                        axi_clk,
    input  logic                        reset,
    input  logic                        aw_valid,
    output logic                        aw_ready,
    input  logic [`PCIE_WR_ADDR_W-1:0]  aw_addr,
    input  logic [`PCIE_WR_LEN_W-1:0]   aw_len,
    input  logic                        w_valid,
    output logic                        w_ready,
    input  logic [31:0]                 w_data,
    input  logic [3:0]                  w_strb,
    input  logic                        w_last,
    output logic                        b_valid,
    input  logic                        b_ready,
    output logic [1:0]                  b_resp,
    output logic                        tx_valid,
    input  logic                        tx_ready,
    output logic [31:0]                 tx_data,
    output logic                        tx_last,
    input  logic                        dma_en,
    input  pcie_wr_pkg::req_id_t        req_id
);

    import pcie_wr_pkg::*;

    logic        cmd_valid;
    logic        cmd_ready;
    wr_cmd_t     cmd;
    logic        hdr_valid;
    logic        hdr_ready;
    tlp_hdr_t    hdr;
    logic        fifo_full;
    logic        push;
    logic [31:0] push_data;
    logic        pop;
    logic [31:0] head;
    logic        not_empty;

    // AXI capture, beats to FIFO, one command per burst
    wr_cmd_stage u_cmd (
        .axi_clk   (axi_clk),
        .reset     (reset),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw_addr   (aw_addr),
        .aw_len    (aw_len),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .w_data    (w_data),
        .w_strb    (w_strb),
        .w_last    (w_last),
        .fifo_full (fifo_full),
        .push      (push),
        .push_data (push_data),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd)
    );

    wr_beat_fifo u_fifo (
        .axi_clk   (axi_clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .full      (fifo_full),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty)
    );

    tlp_hdr_stage u_hdr (
        .axi_clk   (axi_clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .req_id    (req_id),
        .dma_en    (dma_en),
        .hdr_valid (hdr_valid),
        .hdr_ready (hdr_ready),
        .hdr       (hdr)
    );

    // tx serializer and B response
    tlp_tx_stage u_tx (
        .axi_clk   (axi_clk),
        .reset     (reset),
        .hdr_valid (hdr_valid),
        .hdr_ready (hdr_ready),
        .hdr       (hdr),
        .head      (head),
        .not_empty (not_empty),
        .pop       (pop),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .tx_data   (tx_data),
        .tx_last   (tx_last),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .b_resp    (b_resp)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,  // 20 ns clock
    parameter int RESET_CYCLES = 16
) (
    output logic axi_clk,
    output logic reset
);

    initial begin
        axi_clk = 1'b0;
        forever #(HALF_PERIOD) axi_clk = ~axi_clk;
    end

    // released on a rising edge, DUT reset is synchronous
    initial begin
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge axi_clk);
        reset <= 1'b0;
    end

endmodule

// ==== verif/pcie_wr_properties.sv ====
`timescale 1ns/1ps

module pcie_wr_properties (
    input logic        axi_clk,
    input logic        reset,
    input logic        tx_valid,
    input logic        tx_ready,
    input logic [31:0] tx_data,
    input logic        tx_last,
    input logic        b_valid,
    input logic        b_ready,
    input logic [1:0]  b_resp
);

    // stalled tx word held as is until taken
    tx_hold: assert property (@(posedge axi_clk) disable iff (reset)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data) && $stable(tx_last)))
        else $error("tx word changed or withdrawn while stalled");

    b_hold: assert property (@(posedge axi_clk) disable iff (reset)
        (b_valid && !b_ready) |=> (b_valid && $stable(b_resp)))
        else $error("B response changed or withdrawn before acceptance");

    // outputs quiet right after a reset cycle
    quiet_after_reset: assert property (@(posedge axi_clk)
        reset |=> (!tx_valid && !b_valid))
        else $error("valid output high in the cycle after reset");

endmodule

bind pcie_wr_bridge pcie_wr_properties u_props (
    .axi_clk  (axi_clk),
    .reset    (reset),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_data  (tx_data),
    .tx_last  (tx_last),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b_resp   (b_resp)
);

// ==== verif/tb_pcie_wr_bridge.sv ====
`timescale 1ns/1ps
`include "pcie_wr_config.svh"

module tb_pcie_wr_bridge;

    import pcie_wr_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM   = 40;
    localparam int NUM_BURSTS   = NUM_RANDOM + 4;  // four directed bursts first

    logic                       axi_clk, reset;
    logic                       aw_valid, aw_ready;
    logic [`PCIE_WR_ADDR_W-1:0] aw_addr;
    logic [`PCIE_WR_LEN_W-1:0]  aw_len;
    logic                       w_valid, w_ready, w_last;
    logic [31:0]                w_data;
    logic [3:0]                 w_strb;
    logic                       b_valid, b_ready;
    logic [1:0]                 b_resp;
    logic                       tx_valid, tx_ready, tx_last;
    logic [31:0]                tx_data;
    logic                       dma_en;
    req_id_t                    req_id;

    int          seed        = 26777;
    int          ready_seed  = 26777 + 1;  // own stream for the ready process
    int          bursts_sent = 0;
    int          resp_seen   = 0;
    logic [32:0] exp_word [$];  // {last, data}
    logic [1:0]  exp_resp [$];
    logic [31:0] beat_data [0:15];
    logic [3:0]  beat_strb [0:15];

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clk_gen (.axi_clk(axi_clk), .reset(reset));

    pcie_wr_bridge u_pcie_wr_bridge (.*);

    task automatic report_mismatch(string name, logic [31:0] want, logic [31:0] got);
        $display("ERR t=%0t %s expected %h got %h", $time, name, want, got);
        $display("CHECKS FAILED");
        $fatal(1, "wrong value on %s", name);
    endtask

    task automatic report_failure(string what);
        $display("error at t=%0t: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "%s", what);
    endtask

    // expected tx words and B response of one burst
    function automatic void expect_burst(logic [31:0] addr, int beats, logic en, req_id_t rid);
        logic [3:0]  last_be;
        logic [31:0] len_dw;
        logic [31:0] id_dw;
        last_be = (beats == 1) ? 4'h0 : beat_strb[beats-1];
        len_dw  = (32'(`PCIE_WR_FMT_MWR) << 29) | (32'(`PCIE_WR_TYPE_MEM) << 24) | 32'(beats);
        id_dw   = (32'(rid) << 16) | (32'(last_be) << 4) | 32'(beat_strb[0]);
        if (en) begin
            exp_word.push_back({1'b0, len_dw});
            exp_word.push_back({1'b0, id_dw});
            exp_word.push_back({1'b0, addr[31:2], 2'b00});
            for (int i = 0; i < beats; i++) begin
                exp_word.push_back({i == beats - 1, beat_data[i]});
            end
            exp_resp.push_back(`PCIE_WR_RESP_OKAY);
        end else begin
            exp_resp.push_back(`PCIE_WR_RESP_SLVERR);  // absorbed with nothing on tx
        end
    endfunction

    function automatic int random_gap();
        int r;
        r = $random(seed) & 7;
        return (r > 2) ? 0 : r;
    endfunction

    task automatic wait_idle();
        while (resp_seen != bursts_sent) @(posedge axi_clk);
    endtask

    // one AXI write burst with AW first then its beats
    task automatic run_burst(logic [31:0] addr, int beats, logic en, req_id_t rid);
        int gap;
        if (en != dma_en || rid != req_id) begin
            wait_idle();  // static config only moves with the pipeline empty
            dma_en <= en;
            req_id <= rid;
            @(posedge axi_clk);
        end
        for (int i = 0; i < beats; i++) begin
            beat_data[i] = $random(seed);
            beat_strb[i] = 4'($random(seed));
        end
        expect_burst(addr, beats, en, rid);
        bursts_sent++;
        gap = random_gap();
        repeat (gap) @(posedge axi_clk);
        aw_valid <= 1'b1;
        aw_addr  <= addr;
        aw_len   <= 4'(beats - 1);
        @(posedge axi_clk);
        while (!aw_ready) @(posedge axi_clk);
        aw_valid <= 1'b0;
        for (int i = 0; i < beats; i++) begin
            gap = random_gap();
            if (gap != 0) begin
                w_valid <= 1'b0;
                repeat (gap) @(posedge axi_clk);
            end
            w_valid <= 1'b1;
            w_data  <= beat_data[i];
            w_strb  <= beat_strb[i];
            w_last  <= (i == beats - 1);
            @(posedge axi_clk);
            while (!w_ready) @(posedge axi_clk);
        end
        w_valid <= 1'b0;
        w_last  <= 1'b0;
    endtask

    initial begin : ready_gen
        tx_ready <= 1'b0;
        b_ready  <= 1'b0;
        forever begin
            @(posedge axi_clk);
            if (!reset) begin
                tx_ready <= (($random(ready_seed) & 3) != 0);  // about 3 in 4
                b_ready  <= (($random(ready_seed) & 1) == 1);
            end
        end
    end

    always @(posedge axi_clk) begin : compare_outputs
        logic [32:0] want;
        logic [1:0]  want_resp;
        if (!reset && tx_valid && tx_ready) begin
            assert (exp_word.size() > 0)
                else report_failure("tx word seen while no TLP word was expected");
            want = exp_word.pop_front();
            assert (tx_data == want[31:0])
                else report_mismatch("tx_data", want[31:0], tx_data);
            assert (tx_last == want[32])
                else report_mismatch("tx_last", 32'(want[32]), 32'(tx_last));
        end
        if (!reset && b_valid && b_ready) begin
            assert (exp_resp.size() > 0)
                else report_failure("B response with no burst outstanding");
            want_resp = exp_resp.pop_front();
            assert (b_resp == want_resp)
                else report_mismatch("b_resp", 32'(want_resp), 32'(b_resp));
            resp_seen <= resp_seen + 1;
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + NUM_BURSTS * 60) @(posedge axi_clk);
        $display("timeout: bursts still outstanding, %0d of %0d answered", resp_seen, bursts_sent);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        req_id_t     rid;
        logic [31:0] addr;
        int          beats;
        logic        en;
        aw_valid <= 1'b0;
        aw_addr  <= '0;
        aw_len   <= '0;
        w_valid  <= 1'b0;
        w_data   <= '0;
        w_strb   <= '0;
        w_last   <= 1'b0;
        dma_en   <= 1'b1;
        rid = '{bus: 8'h3c, dev: 5'h0a, func: 3'h2};
        req_id   <= rid;
        @(posedge axi_clk);
        while (reset) @(posedge axi_clk);
        run_burst(32'h1000_0044, 1, 1'b1, rid);   // single beat
        run_burst(32'h2000_0100, 16, 1'b1, rid);  // longest burst
        run_burst(32'h3000_0200, 4, 1'b0, rid);   // bus mastering off
        run_burst(32'h3000_0300, 3, 1'b1, rid);   // back on
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if (n % 10 == 5) begin
                rid = req_id_t'(16'($random(seed)));
            end
            addr  = $random(seed);
            beats = 1 + ($random(seed) & 15);
            en    = (($random(seed) & 3) != 0);
            run_burst(addr, beats, en, rid);
        end
        wait_idle();
        if (exp_word.size() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("tx words missing at end of run, %0d never arrived", exp_word.size());
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
logic/pcie_wr_pkg.sv
logic/wr_beat_fifo.sv
logic/wr_cmd_stage.sv
logic/tlp_hdr_stage.sv
logic/tlp_tx_stage.sv
logic/pcie_wr_bridge.sv
verif/tb_clock_gen.sv
verif/pcie_wr_properties.sv
verif/tb_pcie_wr_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
    --top-module tb_pcie_wr_bridge --Mdir obj_dir -o tb_sim > sim.log 2>&1 &&
    ./obj_dir/tb_sim >> sim.log 2>&1 ||
    echo "CHECKS FAILED" >> sim.log

grep -q "CHECKS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
